// ==== common/shift_pkg.sv ====
// Shift unit data types
`default_nettype none

package shift_pkg;

	// Operand and result width
	localparam int DATA_W = 32;

	// Rotate amount width
	localparam int AMT_W = 5;

	// Opaque tag that travels with each command
	localparam int TAG_W = 4;

	// Shift and mask modes
	typedef enum logic [1:0] {
		// Keep bits 0 through sft
		mode_keep_low       = 2'b00,
		// Clear bits 0 through sft
		mode_keep_high      = 2'b01,
		// Plain rotate
		mode_rotate         = 2'b10,
		// Clear bits 0 through sft and fill them with the sign
		mode_keep_high_sign = 2'b11
	} shift_mode_t;

endpackage

`default_nettype wire

// ==== common/flow_pkg.sv ====
// Credit flow defaults
`default_nettype none

package flow_pkg;

	// Ingress command queue depth
	localparam int IN_DEPTH_DEF = 4;

	// Egress result queue depth
	localparam int OUT_DEPTH_DEF = 4;

	// Credit and occupancy counters
	// Wide enough for a depth of up to 7
	localparam int CNT_W = 3;

endpackage

`default_nettype wire

// ==== common/shift_if.sv ====
// Shift command link
`timescale 1ns/100ps
`default_nettype none

interface shift_if ();
	import shift_pkg::*;

	// Forward direction
	logic valid;
	shift_mode_t mode;
	logic [AMT_W-1:0] amt;
	logic [DATA_W-1:0] data;
	logic [TAG_W-1:0] tag;

	// One-cycle credit return from the receiver
	logic credit;

	// Sending side
	modport src (
		output valid, mode, amt, data, tag,
		input credit
	);

	// Receiving side
	modport dst (
		input valid, mode, amt, data, tag,
		output credit
	);

endinterface

`default_nettype wire

// ==== shifter/barrel32.sv ====
// Rotate and mask barrel
`timescale 1ns/100ps
`default_nettype none

module barrel32 (
	output logic [shift_pkg::DATA_W-1:0] z,
	input shift_pkg::shift_mode_t mode,
	input logic [shift_pkg::AMT_W-1:0] sft,
	input logic [shift_pkg::DATA_W-1:0] a
);
	import shift_pkg::*;

	localparam int HALF = DATA_W / 2;

	logic [2*DATA_W-1:0] t;
	logic [DATA_W-1:0] f;
	logic [DATA_W-1:0] dcd;
	logic [DATA_W-1:0] low_mask;
	logic [DATA_W-1:0] high_mask;
	logic clr_high;
	logic clr_low;
	logic sign_fill;
	logic [DATA_W-1:0] opt0;
	logic [DATA_W-1:0] opt1;

	// Rotate left
	// Bits shifted out the top wrap back in at the bottom
	assign t = {{DATA_W{1'b0}}, a} << sft;
	assign f = t[DATA_W-1:0] | t[2*DATA_W-1:DATA_W];

	// One-hot decode of sft in two halves
	assign dcd[HALF-1:0] = sft[AMT_W-1] ? '0 : (HALF'(1) << sft[AMT_W-2:0]);
	assign dcd[DATA_W-1:HALF] = ~sft[AMT_W-1] ? '0 : (HALF'(1) << sft[AMT_W-2:0]);

	// Prefix OR of the decode
	always_comb begin
		// Low mask covers bits 0 through sft
		low_mask[DATA_W-1] = dcd[DATA_W-1];
		for (int i = DATA_W - 2; i >= 0; i--) begin
			low_mask[i] = low_mask[i+1] | dcd[i];
		end
		// High mask covers bits sft+1 upward
		high_mask[0] = 1'b0;
		for (int i = 1; i < DATA_W; i++) begin
			high_mask[i] = high_mask[i-1] | dcd[i-1];
		end
	end

	// Mode decode
	assign clr_high = (mode == mode_keep_low);
	assign clr_low = (mode == mode_keep_high) || (mode == mode_keep_high_sign);
	// Sign fill only when operand is negative
	assign sign_fill = (mode == mode_keep_high_sign) && a[DATA_W-1];

	// Keep term is the inverted OR of the masks to clear
	assign opt0 = ~((clr_high ? high_mask : '0) | (clr_low ? low_mask : '0));

	// Fill term for the sign mode
	assign opt1 = sign_fill ? low_mask : '0;

	// Final AND-OR
	assign z = (f & opt0) | opt1;

endmodule

`default_nettype wire

// ==== shifter/shift_stage.sv ====
// Registered shift stage
`timescale 1ns/100ps
`default_nettype none

module shift_stage #(
	parameter int OUT_DEPTH = flow_pkg::OUT_DEPTH_DEF
) (
	input logic clk,
	input logic arst_n,
	shift_if.dst up,
	shift_if.src down
);
	import shift_pkg::*;
	import flow_pkg::*;

	logic [DATA_W-1:0] result;
	logic [CNT_W-1:0] b_credits;
	logic owe_credit;
	logic grant;

	barrel32 i_barrel32 (
		.z(result),
		.mode(up.mode),
		.sft(up.amt),
		.a(up.data)
	);

	// Single slot toward ingress
	// The slot is freed in the cycle the command arrives, but the credit
	// is only handed back while a link_b credit is left for the next one
	always_comb begin
		if (up.valid) begin
			grant = (b_credits > CNT_W'(1)) || down.credit;
		end else begin
			grant = owe_credit && (b_credits != '0);
		end
	end

	assign up.credit = grant;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			down.valid <= 1'b0;
			b_credits <= CNT_W'(OUT_DEPTH);
			owe_credit <= 1'b0;
		end else begin
			down.valid <= up.valid;
			// Send and return in one cycle cancel out
			b_credits <= b_credits - CNT_W'(up.valid) + CNT_W'(down.credit);
			// Withheld credit stays owed until egress frees a slot
			owe_credit <= (up.valid || owe_credit) && !grant;
		end
	end

	// Result and tag register
	always_ff @(posedge clk) begin
		if (up.valid) begin
			down.data <= result;
			down.tag <= up.tag;
			down.mode <= up.mode;
			down.amt <= up.amt;
		end
	end

endmodule

`default_nettype wire

// ==== design/cmd_ingress.sv ====
// Command ingress queue
`timescale 1ns/100ps
`default_nettype none

module cmd_ingress #(
	parameter int IN_DEPTH = flow_pkg::IN_DEPTH_DEF
) (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input shift_pkg::shift_mode_t in_mode,
	input logic [shift_pkg::AMT_W-1:0] in_amt,
	input logic [shift_pkg::DATA_W-1:0] in_data,
	input logic [shift_pkg::TAG_W-1:0] in_tag,
	output logic in_credit,
	shift_if.src down
);
	import shift_pkg::*;
	import flow_pkg::*;

	localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

	// Command storage
	shift_mode_t mode_q [IN_DEPTH];
	logic [AMT_W-1:0] amt_q [IN_DEPTH];
	logic [DATA_W-1:0] data_q [IN_DEPTH];
	logic [TAG_W-1:0] tag_q [IN_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] s_credits;
	logic pop;

	// Circular pointer advance
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// Head leaves when the stage can take it
	// A credit arriving this cycle counts already
	assign pop = (count != '0) && ((s_credits != '0) || down.credit);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			// Stage has one slot
			s_credits <= CNT_W'(1);
			down.valid <= 1'b0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(in_valid) - CNT_W'(pop);
			s_credits <= s_credits - CNT_W'(pop) + CNT_W'(down.credit);
			down.valid <= pop;
			// Each pop frees a queue slot for the producer
			in_credit <= pop;
		end
	end

	// Queue write
	// Producer credits keep it from overrunning
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mode_q[wr_ptr] <= in_mode;
			amt_q[wr_ptr] <= in_amt;
			data_q[wr_ptr] <= in_data;
			tag_q[wr_ptr] <= in_tag;
		end
	end

	// Head onto link
	always_ff @(posedge clk) begin
		if (pop) begin
			down.mode <= mode_q[rd_ptr];
			down.amt <= amt_q[rd_ptr];
			down.data <= data_q[rd_ptr];
			down.tag <= tag_q[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// ==== design/result_egress.sv ====
// Result egress queue
`timescale 1ns/100ps
`default_nettype none

module result_egress #(
	parameter int OUT_DEPTH = flow_pkg::OUT_DEPTH_DEF,
	parameter int OUT_CREDITS = flow_pkg::OUT_DEPTH_DEF
) (
	input logic clk,
	input logic arst_n,
	shift_if.dst up,
	output logic out_valid,
	output logic [shift_pkg::DATA_W-1:0] out_data,
	output logic [shift_pkg::TAG_W-1:0] out_tag,
	input logic out_credit
);
	import shift_pkg::*;
	import flow_pkg::*;

	localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;

	// Result storage
	logic [DATA_W-1:0] data_q [OUT_DEPTH];
	logic [TAG_W-1:0] tag_q [OUT_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] c_credits;
	logic have_head;
	logic send;
	logic bypass;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(OUT_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign have_head = (count != '0);

	// Send needs a result and a consumer credit
	assign send = (have_head || up.valid) && (c_credits != '0);

	// Empty queue
	// Incoming result goes straight out and keeps its order
	assign bypass = send && !have_head;
	assign push = up.valid && !bypass;
	assign pop = send && have_head;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			c_credits <= CNT_W'(OUT_CREDITS);
			out_valid <= 1'b0;
			up.credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
			c_credits <= c_credits - CNT_W'(send) + CNT_W'(out_credit);
			out_valid <= send;
			// Every send frees one slot whether bypassed or not
			up.credit <= send;
		end
	end

	// Queue write
	always_ff @(posedge clk) begin
		if (push) begin
			data_q[wr_ptr] <= up.data;
			tag_q[wr_ptr] <= up.tag;
		end
	end

	// Output register
	// Head of queue first, else the incoming result
	always_ff @(posedge clk) begin
		if (send) begin
			out_data <= have_head ? data_q[rd_ptr] : up.data;
			out_tag <= have_head ? tag_q[rd_ptr] : up.tag;
		end
	end

endmodule

`default_nettype wire

// ==== design/shift_unit_top.sv ====
// Pipelined shift unit
`timescale 1ns/100ps
`default_nettype none

module shift_unit_top #(
	parameter int IN_DEPTH = flow_pkg::IN_DEPTH_DEF,
	parameter int OUT_DEPTH = flow_pkg::OUT_DEPTH_DEF,
	parameter int OUT_CREDITS = flow_pkg::OUT_DEPTH_DEF
) (
	input logic clk,
	input logic arst_n,
	// Producer
	input logic in_valid,
	input shift_pkg::shift_mode_t in_mode,
	input logic [shift_pkg::AMT_W-1:0] in_amt,
	input logic [shift_pkg::DATA_W-1:0] in_data,
	input logic [shift_pkg::TAG_W-1:0] in_tag,
	output logic in_credit,
	// Consumer
	output logic out_valid,
	output logic [shift_pkg::DATA_W-1:0] out_data,
	output logic [shift_pkg::TAG_W-1:0] out_tag,
	input logic out_credit
);

	// Ingress to stage
	shift_if link_a ();

	// Stage to egress with the result in data
	shift_if link_b ();

	cmd_ingress #(
		.IN_DEPTH(IN_DEPTH)
	) i_cmd_ingress (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_mode(in_mode),
		.in_amt(in_amt),
		.in_data(in_data),
		.in_tag(in_tag),
		.in_credit(in_credit),
		.down(link_a)
	);

	shift_stage #(
		.OUT_DEPTH(OUT_DEPTH)
	) i_shift_stage (
		.clk(clk),
		.arst_n(arst_n),
		.up(link_a),
		.down(link_b)
	);

	result_egress #(
		.OUT_DEPTH(OUT_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) i_result_egress (
		.clk(clk),
		.arst_n(arst_n),
		.up(link_b),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_tag(out_tag),
		.out_credit(out_credit)
	);

endmodule

`default_nettype wire

// ==== sim/tb_shift_unit.sv ====
// Shift unit testbench
`timescale 1ns/100ps
`default_nettype none

module tb_shift_unit;
	import shift_pkg::*;
	import flow_pkg::*;

	localparam int IN_DEPTH = IN_DEPTH_DEF;
	localparam int OUT_DEPTH = OUT_DEPTH_DEF;
	// Fewer consumer credits than egress slots
	localparam int OUT_CREDITS = 3;
	// Far above the length of all phases together
	localparam int MAX_CYCLES = 4000;

	logic clk;
	logic arst_n;
	logic in_valid;
	shift_mode_t in_mode;
	logic [AMT_W-1:0] in_amt;
	logic [DATA_W-1:0] in_data;
	logic [TAG_W-1:0] in_tag;
	logic in_credit;
	logic out_valid;
	logic [DATA_W-1:0] out_data;
	logic [TAG_W-1:0] out_tag;
	logic out_credit;

	// Commands waiting for a producer credit
	shift_mode_t pend_mode [$];
	logic [AMT_W-1:0] pend_amt [$];
	logic [DATA_W-1:0] pend_data [$];
	logic [TAG_W-1:0] pend_tag [$];
	// Expected results and the edge that took each command
	logic [DATA_W-1:0] exp_data [$];
	logic [TAG_W-1:0] exp_tag [$];
	int exp_edge [$];

	int cyc = 0;
	int prod_credits = IN_DEPTH;
	int sent_count = 0;
	int credit_pulses = 0;
	// Results received but not yet credited back
	int owed = 0;
	// Consumer returns a credit every credit_period cycles or never when 0
	int credit_period = 1;
	int stall_recv = 0;
	bit stalling = 1'b0;
	bit started = 1'b0;
	logic [31:0] rng = 32'd34240;
	logic [TAG_W-1:0] next_tag = '0;

	shift_unit_top #(
		.IN_DEPTH(IN_DEPTH),
		.OUT_DEPTH(OUT_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) i_shift_unit_top (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_mode(in_mode),
		.in_amt(in_amt),
		.in_data(in_data),
		.in_tag(in_tag),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_tag(out_tag),
		.out_credit(out_credit)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Rotate left, then mask bits 0 through sft per mode
	function automatic logic [DATA_W-1:0] model_shift(input shift_mode_t mode,
			input logic [AMT_W-1:0] sft, input logic [DATA_W-1:0] a);
		logic [DATA_W-1:0] rot;
		logic [DATA_W-1:0] r;
		for (int i = 0; i < DATA_W; i++) begin
			rot[(i + int'(sft)) % DATA_W] = a[i];
		end
		for (int i = 0; i < DATA_W; i++) begin
			case (mode)
				mode_keep_low: r[i] = (i <= int'(sft)) ? rot[i] : 1'b0;
				mode_keep_high: r[i] = (i <= int'(sft)) ? 1'b0 : rot[i];
				mode_rotate: r[i] = rot[i];
				default: r[i] = (i <= int'(sft)) ? a[DATA_W-1] : rot[i];
			endcase
		end
		return r;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic queue_cmd(input int mode, input int sft, input logic [DATA_W-1:0] a);
		pend_mode.push_back(shift_mode_t'(mode));
		pend_amt.push_back(AMT_W'(sft));
		pend_data.push_back(a);
		pend_tag.push_back(next_tag);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic queue_random(input int n);
		for (int k = 0; k < n; k++) begin
			rng = xorshift32(rng);
			queue_cmd(int'(rng[1:0]), int'(rng[6:2]), xorshift32(rng ^ 32'h5a5a_0f0f));
		end
	endtask

	// All commands sent, answered and credited back
	task automatic wait_drained();
		while (pend_mode.size() != 0 || exp_data.size() != 0 || owed != 0) begin
			@(posedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			report_failure($sformatf("timeout, run not finished after %0d cycles", cyc));
		end
	end

	// Producer and consumer drive 1 ns after each edge
	initial begin
		in_valid = 1'b0;
		in_mode = mode_keep_low;
		in_amt = '0;
		in_data = '0;
		in_tag = '0;
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			out_credit = 1'b0;
			if (pend_mode.size() != 0 && prod_credits > 0) begin
				in_valid = 1'b1;
				in_mode = pend_mode.pop_front();
				in_amt = pend_amt.pop_front();
				in_data = pend_data.pop_front();
				in_tag = pend_tag.pop_front();
				prod_credits--;
				sent_count++;
				started = 1'b1;
				exp_data.push_back(model_shift(in_mode, in_amt, in_data));
				exp_tag.push_back(in_tag);
				// Taken at the next edge
				exp_edge.push_back(cyc + 1);
			end
			if (owed > 0 && credit_period != 0 && (cyc % credit_period) == 0) begin
				out_credit = 1'b1;
				owed--;
			end
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!started) begin
			assert (!in_credit) else report_failure("in_credit pulsed before any command");
			assert (!out_valid) else report_failure("out_valid rose before any command");
		end
		if (in_credit) begin
			credit_pulses++;
			prod_credits++;
			assert (prod_credits <= IN_DEPTH)
				else report_failure("producer credits returned beyond IN_DEPTH");
		end
		if (out_valid) begin
			assert (exp_data.size() != 0) else report_failure("out_valid with no command pending");
			assert (out_data === exp_data[0]) else report_failure(
				$sformatf("mismatch out_data expected %h got %h", exp_data[0], out_data));
			assert (out_tag === exp_tag[0]) else report_failure(
				$sformatf("mismatch out_tag expected %h got %h", exp_tag[0], out_tag));
			assert (cyc - exp_edge[0] >= 3) else report_failure(
				$sformatf("result came %0d cycles after its command", cyc - exp_edge[0]));
			void'(exp_data.pop_front());
			void'(exp_tag.pop_front());
			void'(exp_edge.pop_front());
			owed++;
			if (stalling) begin
				stall_recv++;
				assert (stall_recv <= OUT_CREDITS) else report_failure(
					$sformatf("mismatch out_valid count expected %h got %h", OUT_CREDITS, stall_recv));
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// Quiet outputs before the first command
		repeat (4) @(posedge clk);
		// Every mode at sft 0, 31 and a middle amount with sign bit set and clear
		for (int m = 0; m < 4; m++) begin
			queue_cmd(m, 0, 32'h9a3c_5e71);
			queue_cmd(m, 31, 32'h9a3c_5e71);
			queue_cmd(m, 0, 32'h6a3c_5e71);
			queue_cmd(m, 31, 32'h6a3c_5e71);
			queue_cmd(m, 13, 32'h8000_0001);
		end
		wait_drained();
		// Slow consumer
		credit_period = 3;
		queue_random(60);
		wait_drained();
		// Consumer stall, then resume
		credit_period = 0;
		stalling = 1'b1;
		queue_random(16);
		while (stall_recv < OUT_CREDITS) begin
			@(posedge clk);
		end
		repeat (40) @(posedge clk);
		assert (pend_mode.size() != 0) else report_failure("producer never throttled in stall");
		stalling = 1'b0;
		credit_period = 1;
		wait_drained();
		// Full rate on both sides
		queue_random(100);
		wait_drained();
		assert (credit_pulses == sent_count) else report_failure(
			$sformatf("mismatch in_credit pulses expected %h got %h", sent_count, credit_pulses));
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
common/shift_pkg.sv
common/flow_pkg.sv
common/shift_if.sv
shifter/barrel32.sv
shifter/shift_stage.sv
design/cmd_ingress.sv
design/result_egress.sv
design/shift_unit_top.sv
sim/tb_shift_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the shift unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_shift_unit -f compile.f

output=$(./obj_dir/Vtb_shift_unit 2>&1) || true
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
	exit 0
else
	exit 1
fi
